// File: common/raybox_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the VGA test-pattern engine
// Video timing, Q12.12 format, map overlay geometry,
// border limits, start pose and per-frame move step
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RAYBOX_CONSTS_SVH
`define RAYBOX_CONSTS_SVH

// Fixed point pose format, Q12.12
`define FIX_INT_BITS      12
`define FIX_FRAC_BITS     12

// 640x480 at 25 MHz pixel clock
`define H_VISIBLE         640
`define H_FRONT           16
`define H_SYNC            96
`define H_BACK            48
`define H_TOTAL           (`H_VISIBLE + `H_FRONT + `H_SYNC + `H_BACK)   // 800
`define V_VISIBLE         480
`define V_FRONT           10
`define V_SYNC            2
`define V_BACK            33
`define V_TOTAL           (`V_VISIBLE + `V_FRONT + `V_SYNC + `V_BACK)   // 525

`define MAP_SCALE         4       // Log2 of pixels per map cell
`define MAP_CELLS         16      // Cells per map side
`define MAP_OVERLAY_SIZE  257     // 16 cells of 16 px plus closing gridline

`define BORDER_LEFT       66
`define BORDER_RIGHT      574

`define PLAYER_MOVE       80      // 80/4096 of a cell per frame

// Start pose, raw Q12.12
`define START_PLAYER_X    6144    // 1.5
`define START_PLAYER_Y    55296   // 13.5
`define START_FACING_X    0
`define START_FACING_Y    (-4096) // -1.0, facing up the map
`define START_VPLANE_X    2048    // 0.5
`define START_VPLANE_Y    0

`endif

// File: common/raybox_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Type package for the VGA test-pattern engine
// Fixed point, scan position, colour and map types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "raybox_consts.svh"

package raybox_pkg;

    // Signed Q12.12 pose component
    typedef logic signed [`FIX_INT_BITS+`FIX_FRAC_BITS-1:0] fixed_t;

    // Screen x or y, covers 0..799
    typedef logic [9:0] pixel_coord_t;

    // Free running frame number
    typedef logic [10:0] frame_count_t;

    // One RGB channel, 2 bits per colour
    typedef logic [1:0] colour_t;

    // Map row or column, 16 cells per side
    typedef logic [3:0] map_index_t;

    // Map cell contents
    // 0 empty, 2 pillar, 3 outer wall
    typedef logic [1:0] map_val_t;

endpackage

// File: common/raybox_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal interfaces
// scan_if carries scan position and frame timing
// pose_if carries the player pose registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface scan_if
    import raybox_pkg::*;
();
    pixel_coord_t h;        // Current pixel x
    pixel_coord_t v;        // Current pixel y
    logic         visible;  // Inside the 640x480 window
    logic         tick;     // One clock at h==0, v==0
    frame_count_t frame;

    modport source (output h, output v, output visible, output tick, output frame);
    modport sink   (input  h, input  v, input  visible, input  tick, input  frame);
endinterface

interface pose_if
    import raybox_pkg::*;
();
    fixed_t player_x;
    fixed_t player_y;
    fixed_t facing_x;   // Heading vector
    fixed_t facing_y;
    fixed_t vplane_x;   // View plane, heading turned 90 deg and scaled
    fixed_t vplane_y;

    modport owner (
        output player_x, output player_y,
        output facing_x, output facing_y,
        output vplane_x, output vplane_y
    );
    modport reader (
        input  player_x, input  player_y,
        input  facing_x, input  facing_y,
        input  vplane_x, input  vplane_y
    );
endinterface

// File: src/vga_sync.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VGA 640x480 sync generator
// Scan counters, sync pulses, visible window,
// frame counter and frame-start tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "raybox_consts.svh"

module vga_sync
    import raybox_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    scan_if.source scan,
    output logic   hsync,    // Active low
    output logic   vsync     // Active low
);

    localparam int H_SYNC_START = `H_VISIBLE + `H_FRONT;    // 656
    localparam int H_SYNC_END   = H_SYNC_START + `H_SYNC;   // First h after pulse, 752
    localparam int V_SYNC_START = `V_VISIBLE + `V_FRONT;    // 490
    localparam int V_SYNC_END   = V_SYNC_START + `V_SYNC;   // 492

    pixel_coord_t h;
    pixel_coord_t v;
    frame_count_t frame;
    logic         h_last;   // Last clock of a line
    logic         v_last;   // Last line of a frame

    assign h_last = (h == pixel_coord_t'(`H_TOTAL - 1));
    assign v_last = (v == pixel_coord_t'(`V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            h     <= '0;
            v     <= '0;
            frame <= '0;
        end else if (h_last) begin
            h <= '0;            // Line wrap
            if (v_last) begin
                v     <= '0;
                frame <= frame + 1'b1;  // Counts whole frames
            end else begin
                v <= v + 1'b1;
            end
        end else begin
            h <= h + 1'b1;
        end
    end

    // Sync pulses decoded straight from the counters
    assign hsync = !(h >= H_SYNC_START && h < H_SYNC_END);
    assign vsync = !(v >= V_SYNC_START && v < V_SYNC_END);

    assign scan.h       = h;
    assign scan.v       = v;
    assign scan.frame   = frame;
    assign scan.visible = (h < `H_VISIBLE) && (v < `V_VISIBLE);
    assign scan.tick    = (h == '0) && (v == '0);   // Start of frame, animation step

endmodule

// File: src/player_state.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Player pose registers
// Start pose on reset, host overwrite on visible
// rows, per-frame motion on the frame-start tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "raybox_consts.svh"

module player_state
    import raybox_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    scan_if.sink   scan,
    input  logic   move_l,
    input  logic   move_r,
    input  logic   move_f,
    input  logic   move_b,
    input  logic   write_new_position,  // Host load of the new_* values
    input  fixed_t new_player_x,
    input  fixed_t new_player_y,
    input  fixed_t new_facing_x,
    input  fixed_t new_facing_y,
    input  fixed_t new_vplane_x,
    input  fixed_t new_vplane_y,
    pose_if.owner  pose
);

    localparam fixed_t MOVE_STEP = fixed_t'(`PLAYER_MOVE);

    fixed_t player_x;
    fixed_t player_y;
    fixed_t facing_x;
    fixed_t facing_y;
    fixed_t vplane_x;
    fixed_t vplane_y;
    logic   host_load;

    // Host writes only land while rows are being drawn
    assign host_load = (scan.v < `V_VISIBLE) && write_new_position;

    always_ff @(posedge clk) begin
        if (reset) begin
            player_x <= fixed_t'(`START_PLAYER_X);
            player_y <= fixed_t'(`START_PLAYER_Y);
            facing_x <= fixed_t'(`START_FACING_X);
            facing_y <= fixed_t'(`START_FACING_Y);
            vplane_x <= fixed_t'(`START_VPLANE_X);
            vplane_y <= fixed_t'(`START_VPLANE_Y);
        end else if (host_load) begin
            player_x <= new_player_x;
            player_y <= new_player_y;
            facing_x <= new_facing_x;
            facing_y <= new_facing_y;
            vplane_x <= new_vplane_x;
            vplane_y <= new_vplane_y;
        end else if (scan.tick) begin
            // Axis aligned steps, left wins over right
            if (move_l)
                player_x <= player_x - MOVE_STEP;
            else if (move_r)
                player_x <= player_x + MOVE_STEP;

            // Forward is up the map, i.e. smaller y
            if (move_f)
                player_y <= player_y - MOVE_STEP;
            else if (move_b)
                player_y <= player_y + MOVE_STEP;
        end
    end

    assign pose.player_x = player_x;
    assign pose.player_y = player_y;
    assign pose.facing_x = facing_x;
    assign pose.facing_y = facing_y;
    assign pose.vplane_x = vplane_x;
    assign pose.vplane_y = vplane_y;

endmodule

// File: map/map_rom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16x16 map contents as combinational logic
// Outer wall ring with a grid of pillars inside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "raybox_consts.svh"

module map_rom
    import raybox_pkg::*;
(
    input  map_index_t row,
    input  map_index_t col,
    output map_val_t   val
);

    localparam map_index_t LAST_CELL = map_index_t'(`MAP_CELLS - 1);

    logic on_edge;      // Outer ring of cells
    logic on_pillar;    // Even row and even column

    assign on_edge = (row == '0) || (row == LAST_CELL)
                  || (col == '0) || (col == LAST_CELL);

    assign on_pillar = !row[0] && !col[0];

    always_comb begin
        if (on_edge)
            val = map_val_t'(3);    // Outer wall
        else if (on_pillar)
            val = map_val_t'(2);
        else
            val = '0;               // Open floor
    end

endmodule

// File: map/map_overlay.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top-left map overlay
// Region, gridline, player cell and player pixel
// detection, and the overlay colour
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "raybox_consts.svh"

module map_overlay
    import raybox_pkg::*;
(
    scan_if.sink   scan,
    pose_if.reader pose,
    input  logic    show_map,
    output logic    in_overlay,
    output colour_t overlay_red,
    output colour_t overlay_green,
    output colour_t overlay_blue
);

    localparam int IDX_BITS = $bits(map_index_t);

    map_index_t cell_col;       // Map cell under the scan
    map_index_t cell_row;
    map_index_t player_col;     // Low integer bits of the player position
    map_index_t player_row;
    map_val_t   cell_val;
    logic       in_gridline;
    logic       in_player_cell;
    logic       in_player_pixel;

    assign cell_col   = scan.h[`MAP_SCALE +: IDX_BITS];
    assign cell_row   = scan.v[`MAP_SCALE +: IDX_BITS];
    assign player_col = pose.player_x[`FIX_FRAC_BITS +: IDX_BITS];
    assign player_row = pose.player_y[`FIX_FRAC_BITS +: IDX_BITS];

    map_rom map_rom_i (
        .row (cell_row),
        .col (cell_col),
        .val (cell_val)
    );

    assign in_overlay = show_map && (scan.h < `MAP_OVERLAY_SIZE) && (scan.v < `MAP_OVERLAY_SIZE);

    // First pixel of each cell in either axis draws the grid
    assign in_gridline = (scan.h[`MAP_SCALE-1:0] == '0) || (scan.v[`MAP_SCALE-1:0] == '0);

    assign in_player_cell = (cell_col == player_col) && (cell_row == player_row);

    // Top fraction bits pick the pixel inside the cell
    assign in_player_pixel = in_player_cell
        && (scan.h[`MAP_SCALE-1:0] == pose.player_x[`FIX_FRAC_BITS-1 -: `MAP_SCALE])
        && (scan.v[`MAP_SCALE-1:0] == pose.player_y[`FIX_FRAC_BITS-1 -: `MAP_SCALE]);

    always_comb begin
        if (in_player_pixel)
            {overlay_red, overlay_green, overlay_blue} = {2'd3, 2'd3, 2'd0};   // Yellow
        else if (in_player_cell)
            {overlay_red, overlay_green, overlay_blue} = {2'd0, 2'd1, 2'd0};   // Dark green
        else if (in_gridline)
            {overlay_red, overlay_green, overlay_blue} = {2'd0, 2'd0, 2'd1};   // Dark blue
        else
            {overlay_red, overlay_green, overlay_blue} = {2'd0, 2'd0, cell_val};
    end

endmodule

// File: src/pixel_colour.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel colour select
// Overlay over border over ceiling and floor,
// blanked outside the visible window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "raybox_consts.svh"

module pixel_colour
    import raybox_pkg::*;
(
    scan_if.sink    scan,
    input  logic    in_overlay,
    input  colour_t overlay_red,
    input  colour_t overlay_green,
    input  colour_t overlay_blue,
    output colour_t red,
    output colour_t green,
    output colour_t blue
);

    localparam int HALF_HEIGHT = `V_VISIBLE / 2;

    logic    in_border;
    logic    ceiling;
    colour_t background;    // Grey level, same on all channels
    colour_t r;             // Ungated colour
    colour_t g;
    colour_t b;

    assign in_border  = (scan.h < `BORDER_LEFT) || (scan.h >= `BORDER_RIGHT);
    assign ceiling    = scan.v < HALF_HEIGHT;
    assign background = ceiling ? colour_t'(1) : colour_t'(2);   // Dark over light grey

    always_comb begin
        if (in_overlay) begin
            r = overlay_red;
            g = overlay_green;
            b = overlay_blue;
        end else if (in_border) begin
            r = colour_t'(1);       // Dark purple
            g = '0;
            b = colour_t'(1);
        end else begin
            r = background;
            g = background;
            b = background;
        end
    end

    // Black during blanking
    assign red   = scan.visible ? r : '0;
    assign green = scan.visible ? g : '0;
    assign blue  = scan.visible ? b : '0;

endmodule

// File: src/raybox_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VGA test-pattern engine top level
// Sync, player state, map overlay and colour select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module raybox_top
    import raybox_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         show_map,          // Map overlay on
    input  logic         move_l,
    input  logic         move_r,
    input  logic         move_f,
    input  logic         move_b,
    input  logic         write_new_position,
    input  fixed_t       new_player_x,
    input  fixed_t       new_player_y,
    input  fixed_t       new_facing_x,
    input  fixed_t       new_facing_y,
    input  fixed_t       new_vplane_x,
    input  fixed_t       new_vplane_y,
    output colour_t      red,
    output colour_t      green,
    output colour_t      blue,
    output logic         hsync,
    output logic         vsync,
    output pixel_coord_t px,                // Scan x
    output pixel_coord_t py,                // Scan y
    output frame_count_t frame_num
);

    scan_if scan ();
    pose_if pose ();

    logic    in_overlay;
    colour_t overlay_red;
    colour_t overlay_green;
    colour_t overlay_blue;

    vga_sync vga_sync_i (
        .clk   (clk),
        .reset (reset),
        .scan  (scan.source),
        .hsync (hsync),
        .vsync (vsync)
    );

    player_state player_state_i (
        .clk                (clk),
        .reset              (reset),
        .scan               (scan.sink),
        .move_l             (move_l),
        .move_r             (move_r),
        .move_f             (move_f),
        .move_b             (move_b),
        .write_new_position (write_new_position),
        .new_player_x       (new_player_x),
        .new_player_y       (new_player_y),
        .new_facing_x       (new_facing_x),
        .new_facing_y       (new_facing_y),
        .new_vplane_x       (new_vplane_x),
        .new_vplane_y       (new_vplane_y),
        .pose               (pose.owner)
    );

    map_overlay map_overlay_i (
        .scan          (scan.sink),
        .pose          (pose.reader),
        .show_map      (show_map),
        .in_overlay    (in_overlay),
        .overlay_red   (overlay_red),
        .overlay_green (overlay_green),
        .overlay_blue  (overlay_blue)
    );

    pixel_colour pixel_colour_i (
        .scan          (scan.sink),
        .in_overlay    (in_overlay),
        .overlay_red   (overlay_red),
        .overlay_green (overlay_green),
        .overlay_blue  (overlay_blue),
        .red           (red),
        .green         (green),
        .blue          (blue)
    );

    assign px        = scan.h;
    assign py        = scan.v;
    assign frame_num = scan.frame;

endmodule

// File: sim/tb_raybox.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the VGA pattern engine
// Sync and frame count sweep over one frame, then
// pattern-file tests of colour at sample pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "raybox_consts.svh"

module tb_raybox
    import raybox_pkg::*;
();

    localparam string  PATTERN_FILE = "sim/raybox_patterns.txt";
    localparam longint FRAME_CYCLES = `H_TOTAL * `V_TOTAL;     // 420000 clocks

    logic         clk;
    logic         reset;
    logic         show_map;
    logic         move_l;
    logic         move_r;
    logic         move_f;
    logic         move_b;
    logic         write_new_position;
    fixed_t       new_player_x;
    fixed_t       new_player_y;
    fixed_t       new_facing_x;
    fixed_t       new_facing_y;
    fixed_t       new_vplane_x;
    fixed_t       new_vplane_y;
    colour_t      red;
    colour_t      green;
    colour_t      blue;
    logic         hsync;
    logic         vsync;
    pixel_coord_t px;
    pixel_coord_t py;
    frame_count_t frame_num;

    string  pattern_lines[$];       // Data lines of the pattern file
    int     tests_run     = 0;
    int     tests_failed  = 0;
    bit     test_ok;                // Cleared by any failing check
    longint cycle_count   = 0;
    longint timeout_limit = 0;      // 0 until the tests are counted

    raybox_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, a test never reached its sample point",
                     cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_colour(input string name, input colour_t exp_r, input colour_t exp_g,
                                input colour_t exp_b);
        if (red !== exp_r || green !== exp_g || blue !== exp_b) begin
            $display("Mismatch %s at (%0d,%0d): expected rgb %0d %0d %0d, actual %0d %0d %0d",
                     name, px, py, exp_r, exp_g, exp_b, red, green, blue);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_sync(input string name, input logic exp_hs, input logic exp_vs);
        if (hsync !== exp_hs || vsync !== exp_vs) begin
            $display("Mismatch %s at (%0d,%0d): expected hsync %b vsync %b, actual %b %b",
                     name, px, py, exp_hs, exp_vs, hsync, vsync);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_frame(input string name, input frame_count_t exp_frame);
        if (frame_num !== exp_frame) begin
            $display("Mismatch %s at (%0d,%0d): expected frame %0d, actual %0d",
                     name, px, py, exp_frame, frame_num);
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_ok) begin
            $display("PASS  %s", name);
        end else begin
            $display("FAIL  %s", name);
            tests_failed++;
        end
    endtask

    task automatic load_patterns();
        int    fd;
        string line;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#")
                    pattern_lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    // Stable sample point, DUT inputs change only on rising edges
    task automatic wait_pixel(input pixel_coord_t x, input pixel_coord_t y);
        do @(negedge clk); while (!(px == x && py == y));
    endtask

    // One-cycle host write well inside a visible row
    task automatic write_pose(input fixed_t x, input fixed_t y);
        do @(negedge clk); while (!(py >= 1 && py < 470));
        @(posedge clk);
        new_player_x       <= x;
        new_player_y       <= y;
        new_facing_x       <= fixed_t'(`START_FACING_X);   // Heading and plane kept
        new_facing_y       <= fixed_t'(`START_FACING_Y);
        new_vplane_x       <= fixed_t'(`START_VPLANE_X);
        new_vplane_y       <= fixed_t'(`START_VPLANE_Y);
        write_new_position <= 1'b1;
        @(posedge clk);
        write_new_position <= 1'b0;
    endtask

    // Returns on the rising edge that applies the last tick
    task automatic wait_ticks(input int count);
        repeat (count) begin
            wait_pixel('0, '0);     // Tick is high here
            @(posedge clk);
        end
    endtask

    task automatic sweep_sync();
        string  name = "sync_and_blanking";
        logic   exp_hs;
        logic   exp_vs;
        longint n;
        test_ok = 1'b1;
        @(posedge clk);
        show_map <= 1'b1;           // Overlay must blank too
        wait_pixel('0, '0);
        check_frame(name, frame_count_t'(1));   // Reset frame already wrapped once
        for (n = 0; n < FRAME_CYCLES && test_ok; n++) begin
            exp_hs = !(px >= 656 && px <= 751);
            exp_vs = !(py == 490 || py == 491);
            check_sync(name, exp_hs, exp_vs);
            if (px >= 640 || py >= 480)
                check_colour(name, '0, '0, '0);
            @(negedge clk);
        end
        if (n == FRAME_CYCLES)
            check_frame(name, frame_count_t'(2));   // One more full frame swept
        report_test(name);
    endtask

    task automatic run_pattern(input string line);
        string       name;
        int          show;
        int          ml;
        int          mr;
        int          mf;
        int          mb;
        int          wr;
        int          ticks;
        int          sx;
        int          sy;
        int          er;
        int          eg;
        int          eb;
        logic [23:0] pos_x;
        logic [23:0] pos_y;
        int          fields;
        test_ok = 1'b1;
        fields = $sscanf(line, "%s %d %d %d %d %d %d %h %h %d %d %d %d %d %d", name, show,
                         ml, mr, mf, mb, wr, pos_x, pos_y, ticks, sx, sy, er, eg, eb);
        if (fields != 15) begin
            $display("Pattern line could not be parsed: %s", line);
            test_ok = 1'b0;
            report_test("bad_pattern_line");
        end else begin
            @(posedge clk);
            show_map <= show[0];
            if (wr != 0)
                write_pose(fixed_t'(pos_x), fixed_t'(pos_y));
            if (ticks > 0) begin
                @(posedge clk);
                move_l <= ml[0];
                move_r <= mr[0];
                move_f <= mf[0];
                move_b <= mb[0];
                wait_ticks(ticks);
                move_l <= 1'b0;     // Released at the last applied tick
                move_r <= 1'b0;
                move_f <= 1'b0;
                move_b <= 1'b0;
            end
            wait_pixel(pixel_coord_t'(sx), pixel_coord_t'(sy));
            check_colour(name, colour_t'(er), colour_t'(eg), colour_t'(eb));
            report_test(name);
        end
    endtask

    initial begin
        reset              = 1'b1;
        show_map           = 1'b0;
        move_l             = 1'b0;
        move_r             = 1'b0;
        move_f             = 1'b0;
        move_b             = 1'b0;
        write_new_position = 1'b0;
        new_player_x       = '0;
        new_player_y       = '0;
        new_facing_x       = '0;
        new_facing_y       = '0;
        new_vplane_x       = '0;
        new_vplane_y       = '0;
        load_patterns();
        // Two frames per test, plus the sweep and some slack
        timeout_limit = (pattern_lines.size() + 1 + 2) * 2 * FRAME_CYCLES;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        if (pattern_lines.size() == 0) begin
            $display("Pattern file %s is missing or holds no tests", PATTERN_FILE);
            tests_failed++;
        end else begin
            sweep_sync();
            foreach (pattern_lines[i])
                run_pattern(pattern_lines[i]);
        end
        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: sim/raybox_patterns.txt
# name show_map move_l move_r move_f move_b write pos_x pos_y ticks px py red green blue
# pos_x pos_y are raw Q12.12 hex used when write is 1, ticks counts frame starts to wait
player_pixel_start 1 0 0 0 0 0 0 0 0 24 216 3 3 0
player_cell_start 1 0 0 0 0 0 0 0 0 20 220 0 1 0
gridline 1 0 0 0 0 0 0 0 0 32 5 0 0 1
wall_cell 1 0 0 0 0 0 0 0 0 8 8 0 0 3
pillar_cell 1 0 0 0 0 0 0 0 0 40 40 0 0 2
open_cell 1 0 0 0 0 0 0 0 0 56 40 0 0 0
overlay_last_column 1 0 0 0 0 0 0 0 0 256 100 0 0 1
past_overlay 1 0 0 0 0 0 0 0 0 257 100 1 1 1
ceiling 0 0 0 0 0 0 0 0 0 320 100 1 1 1
floor 0 0 0 0 0 0 0 0 0 320 400 2 2 2
border_left 0 0 0 0 0 0 0 0 0 10 300 1 0 1
border_right 0 0 0 0 0 0 0 0 0 600 300 1 0 1
map_off_corner 0 0 0 0 0 0 0 0 0 8 8 1 0 1
blank_right 1 0 0 0 0 0 0 0 0 700 100 0 0 0
blank_bottom 1 0 0 0 0 0 0 0 0 100 500 0 0 0
host_write 1 0 0 0 0 1 5400 7C00 0 84 124 3 3 0
host_write_cell 1 0 0 0 0 0 0 0 0 85 124 0 1 0
move_r_before 1 0 0 0 0 1 50F0 7C00 0 80 124 3 3 0
move_r_step 1 0 1 0 0 0 0 0 1 81 124 3 3 0
move_r_old_pixel 1 0 0 0 0 0 0 0 0 80 124 0 1 0
move_l_step 1 1 0 0 0 0 0 0 1 80 124 3 3 0
move_f_before 1 0 0 0 0 1 5400 7100 0 84 113 3 3 0
move_f_step 1 0 0 1 0 0 0 0 1 84 112 3 3 0
move_b_step 1 0 0 0 1 0 0 0 1 84 113 3 3 0

// File: sources.f
+incdir+common
common/raybox_pkg.sv
common/raybox_ifs.sv
src/vga_sync.sv
src/player_state.sv
map/map_rom.sv
map/map_overlay.sv
src/pixel_colour.sv
src/raybox_top.sv
sim/tb_raybox.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f sources.f \
    --top-module tb_raybox \
    -o tb_raybox

output=$(./obj_dir/tb_raybox)
echo "$output"

if grep -qx 'All tests passed!' <<< "$output"; then
    exit 0
else
    exit 1
fi
